// File: Makefile
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing --assert -j 0
TOP = dsp_ctrl_tb
FILELIST = sources.f
PASS_MSG = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: source/do_loop_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
/* DO/REDO loop controller: instruction and repeat counters,
   cache position and loop boundary strobes */
module do_loop_ctrl import dsp_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ph1,
    input  logic double,
    input  logic do_load,
    input  ni_t  do_ni_in,
    input  k_t   do_k_in,
    input  logic do_redo_in,
    input  logic do_short,
    output logic do_busy,
    output logic do_incache,
    output logic do_extend,
    output logic do_start,
    output logic do_out,
    output logic do_redo,
    output ni_t  do_pc
);

    ni_t  ni_cnt, ni_q, ni_cur;
    k_t   k_cnt, k_q, k_cur;
    logic redo_q, first_done, first_pass, over;

    // Freshly loaded parameters apply in the load slot itself
    assign ni_cur  = do_load ? do_ni_in : ni_q;
    assign k_cur   = do_load ? do_k_in : k_q;
    assign do_redo = do_load ? do_redo_in : redo_q;

    assign over     = ni_cnt == ni_cur;             // Last instruction of a pass
    assign do_busy  = k_cnt != '0;
    assign do_pc    = ni_cnt;

    // End of the first pass not yet flagged
    assign first_pass = ((over && k_cnt == k_cur && do_busy) || do_short)
                        && !(first_done && !do_load);

    assign do_start  = (!do_redo && first_pass) || (do_redo && !do_busy);
    assign do_out    = do_busy && over && k_cnt == k_t'(1) && !double;
    assign do_extend = (first_pass && !do_redo) || do_out;

    // Counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ni_cnt <= '0;
            k_cnt  <= '0;
        end else if (ph1) begin
            if (do_load) begin
                ni_cnt <= (do_redo_in || do_short) ? ni_t'(0) : ni_t'(1);
                k_cnt  <= do_k_in;
            end else if (!double && do_busy) begin
                ni_cnt <= over ? '0 : ni_cnt + 1'b1;
                if (over) begin
                    k_cnt <= k_cnt - 1'b1;
                end
            end
        end
    end

    // Loop parameters and state flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ni_q       <= '0;
            k_q        <= '0;
            redo_q     <= 1'b0;
            first_done <= 1'b0;
            do_incache <= 1'b0;
        end else if (ph1) begin
            if (do_load) begin
                ni_q <= do_ni_in;
                k_q  <= do_k_in;
            end
            redo_q <= do_out ? 1'b0 : do_redo;      // Sequence over
            if (do_extend) begin
                first_done <= 1'b1;
            end else if (do_load) begin
                first_done <= 1'b0;
            end
            if (first_pass && !do_redo) begin
                do_incache <= 1'b1;                 // Body now held in cache
            end else if (do_out) begin
                do_incache <= 1'b0;
            end
        end
    end

endmodule
`default_nettype wire

// File: source/dsp_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
/* Controller top: decoder, DO loop controller and interrupt gate */
module dsp_ctrl import dsp_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ph1,
    input  logic [instr_w-1:0]     rom_dout,
    input  logic                   con_result,
    input  logic                   irq,
    output logic                   goto_ja, goto_b, call_ja, pc_halt, con_check,
    output logic                   short_load, long_load, acc_load, ram_load,
    output logic                   post_load, ram_we,
    output logic                   xaau_imm_load, xaau_ram_load, xaau_acc_load,
    output logic                   dau_rmux_load, dau_imm_load, dau_ram_load, dau_acc_load,
    output logic                   st_a0, st_a1, st_ah, acc_sel,
    output logic [r_w-1:0]         rsel, r_field,
    output logic [1:0]             a_field, y_field, inc_sel,
    output logic                   step_sel, ksel,
    output logic [simm_w-1:0]      short_imm,
    output logic [instr_w-1:0]     long_imm,
    output logic [i_w-1:0]         i_field,
    output opcode_t                t_field,
    output logic                   irq_start, iack,
    output logic                   do_start, do_out, do_short, do_redo, do_save,
    output logic [instr_w-t_w-1:0] do_data,
    output ni_t                    do_pc,
    output logic                   fault
);

    logic double;       // Two-cycle instruction in progress
    logic do_load;
    ni_t  do_ni_in;
    k_t   do_k_in;
    logic do_redo_in;
    logic do_busy, do_incache, do_extend;
    logic irq_take, iret_seen;

    instr_decoder u_decoder (.*);

    do_loop_ctrl u_do_loop (.*);

    irq_gate u_irq_gate (.*);

endmodule
`default_nettype wire

// File: source/dsp_ctrl_pkg.sv
`default_nettype none
/* Field widths, count types, opcodes and select codes
   for the DSP instruction-decode controller */
package dsp_ctrl_pkg;

    // Instruction word layout
    localparam int instr_w = 16;
    localparam int t_w     = 5;     // Opcode field
    localparam int r_w     = 3;
    localparam int ni_w    = 4;     // DO instruction count
    localparam int k_w     = 7;     // DO repeat count
    localparam int i_w     = 12;
    localparam int simm_w  = 9;

    typedef logic [t_w-1:0]  opcode_t;
    typedef logic [ni_w-1:0] ni_t;
    typedef logic [k_w-1:0]  k_t;

    // T field values
    localparam opcode_t op_goto_ja    = 5'b00000;  // Also 00001
    localparam opcode_t op_short_imm  = 5'b00010;  // Also 00011
    localparam opcode_t op_call_ja    = 5'b10000;  // Also 10001
    localparam opcode_t op_goto_b     = 5'b11000;
    localparam opcode_t op_load_acc_r = 5'b01000;  // aT=R
    localparam opcode_t op_r_a0       = 5'b01001;
    localparam opcode_t op_r_a1       = 5'b01011;
    localparam opcode_t op_long_imm   = 5'b01010;
    localparam opcode_t op_r_y        = 5'b01111;
    localparam opcode_t op_y_r        = 5'b01100;
    localparam opcode_t op_if_con     = 5'b11010;
    localparam opcode_t op_do         = 5'b01110;

    localparam logic [2:0] rsel_dau = 3'b010;  // Accumulator path through the DAU

    // Y post-modify increment
    localparam logic [1:0] inc_minus1 = 2'd0;
    localparam logic [1:0] inc_zero   = 2'd1;
    localparam logic [1:0] inc_plus1  = 2'd2;

    // Destination register class in bits 9:7
    localparam logic [2:0] dst_yaau = 3'b000;
    localparam logic [2:0] dst_xaau = 3'b001;
    localparam logic [2:0] dst_dau  = 3'b010;

    // No interrupt entry while one of these is fetched
    localparam int irq_block_n = 7;
    localparam opcode_t irq_block_ops [irq_block_n] = '{
        op_goto_ja, op_goto_ja | 5'd1, op_do, op_call_ja,
        op_call_ja | 5'd1, op_goto_b, op_if_con
    };

endpackage
`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none
/* Instruction decoder: ROM word to registered strobes, register fields
   and DO loop parameters */
module instr_decoder import dsp_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ph1,
    input  logic [instr_w-1:0]     rom_dout,
    input  logic                   con_result,
    input  logic                   do_busy,
    input  logic                   do_incache,
    input  logic                   do_extend,
    input  logic                   irq_take,
    output logic                   goto_ja, goto_b, call_ja, pc_halt, con_check,
    output logic                   short_load, long_load, acc_load, ram_load,
    output logic                   post_load, ram_we,
    output logic                   xaau_imm_load, xaau_ram_load, xaau_acc_load,
    output logic                   dau_rmux_load, dau_imm_load, dau_ram_load, dau_acc_load,
    output logic                   st_a0, st_a1, st_ah, acc_sel,
    output logic [r_w-1:0]         rsel, r_field,
    output logic [1:0]             a_field, y_field, inc_sel,
    output logic                   step_sel, ksel,
    output logic [simm_w-1:0]      short_imm,
    output logic [instr_w-1:0]     long_imm,
    output logic [i_w-1:0]         i_field,
    output opcode_t                t_field,
    output logic                   irq_start, double,
    output logic                   do_load, do_redo_in, do_short, do_save,
    output ni_t                    do_ni_in,
    output k_t                     do_k_in,
    output logic [instr_w-t_w-1:0] do_data,
    output logic                   iret_seen, fault
);

    opcode_t    op;
    logic       con_ok, iret, y_load;
    logic [2:0] dst;
    logic [1:0] pm_inc;
    logic       pm_step;

    assign op       = rom_dout[instr_w-1 -: t_w];
    assign dst      = rom_dout[9:7];
    assign con_ok   = !con_check || con_result;     // Previous if-CON outcome
    assign iret     = rom_dout[10:8] == 3'b001;
    assign y_load   = (op == op_r_y) && !rom_dout[10];
    assign long_imm = rom_dout;

    // Y post-modify mode
    always_comb begin
        pm_inc  = inc_zero;
        pm_step = 1'b0;
        case (rom_dout[1:0])
            2'd0: pm_inc = inc_zero;      // *rN
            2'd1: pm_inc = inc_plus1;     // *rN++
            2'd2: pm_inc = inc_minus1;    // *rN--
            default: pm_step = 1'b1;      // *rN++j
        endcase
    end

    always_ff @(posedge clk) begin
        if (ph1) begin
            t_field    <= op;
            i_field    <= rom_dout[i_w-1:0];
            y_field    <= rom_dout[3:2];
            short_imm  <= rom_dout[simm_w-1:0];
            // Only read while do_load is high
            do_redo_in <= rom_dout[k_w +: ni_w] == '0;
            do_ni_in   <= rom_dout[k_w +: ni_w] - 1'b1;
            do_k_in    <= (rom_dout[k_w +: ni_w] == ni_t'(1)) ?
                          rom_dout[k_w-1:0] - 1'b1 : rom_dout[k_w-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {goto_ja, goto_b, call_ja, pc_halt, con_check} <= '0;
            {short_load, long_load, acc_load, ram_load, post_load, ram_we} <= '0;
            {xaau_imm_load, xaau_ram_load, xaau_acc_load} <= '0;
            {dau_rmux_load, dau_imm_load, dau_ram_load, dau_acc_load} <= '0;
            {st_a0, st_a1, st_ah, acc_sel} <= '0;
            rsel      <= '0;
            r_field   <= '0;
            a_field   <= '0;
            inc_sel   <= '0;
            step_sel  <= 1'b0;
            ksel      <= 1'b0;
            irq_start <= 1'b0;
            double    <= 1'b0;
            {do_load, do_short, do_save, iret_seen} <= '0;
            do_data   <= '0;
            fault     <= 1'b0;
        end else if (ph1) begin
            {goto_ja, goto_b, call_ja, pc_halt, con_check} <= '0;
            {short_load, long_load, acc_load, ram_load, post_load, ram_we} <= '0;
            {xaau_imm_load, xaau_ram_load, xaau_acc_load} <= '0;
            {dau_rmux_load, dau_imm_load, dau_ram_load, dau_acc_load} <= '0;
            {st_a0, st_a1, st_ah, acc_sel} <= '0;
            a_field   <= '0;
            irq_start <= 1'b0;
            double    <= 1'b0;
            {do_load, do_short, do_save, iret_seen} <= '0;

            if (!double) begin
                if (irq_take) begin         // Interrupt entry
                    goto_ja   <= 1'b1;
                    irq_start <= 1'b1;
                    pc_halt   <= 1'b1;
                    double    <= 1'b1;
                end else begin
                    case (op)
                        op_goto_ja, op_goto_ja | 5'd1: begin
                            goto_ja <= con_ok;
                            pc_halt <= 1'b1;
                            double  <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        op_short_imm, op_short_imm | 5'd1: begin
                            short_load <= 1'b1;
                            r_field    <= rom_dout[11:9] ^ 3'b100;
                        end
                        op_call_ja, op_call_ja | 5'd1: begin
                            call_ja <= con_ok;
                            pc_halt <= 1'b1;
                            double  <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        op_goto_b: begin
                            goto_b    <= con_ok || iret;  // iret is unconditional
                            iret_seen <= iret;
                            pc_halt   <= 1'b1;
                            double    <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        op_load_acc_r: begin
                            r_field       <= rom_dout[6:4];
                            rsel          <= rom_dout[8:6];
                            dau_rmux_load <= 1'b1;
                            st_a0         <= rom_dout[10];
                            st_a1         <= !rom_dout[10];
                            st_ah         <= 1'b1;
                            pc_halt       <= 1'b1;
                            double        <= 1'b1;
                        end
                        op_r_a0, op_r_a1: begin
                            r_field       <= rom_dout[6:4];
                            a_field       <= {1'b1, rom_dout[12]};
                            rsel          <= rsel_dau;
                            acc_sel       <= 1'b1;
                            acc_load      <= rom_dout[8:7] == dst_yaau[1:0];
                            xaau_acc_load <= rom_dout[8:7] == dst_xaau[1:0];
                            dau_acc_load  <= rom_dout[8:7] == dst_dau[1:0];
                            pc_halt       <= 1'b1;
                            double        <= 1'b1;
                        end
                        op_long_imm: begin
                            long_load     <= dst == dst_yaau;
                            xaau_imm_load <= dst == dst_xaau;
                            dau_imm_load  <= dst == dst_dau;
                            r_field       <= rom_dout[6:4];
                            double        <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        op_r_y, op_y_r: begin
                            ram_load      <= y_load && dst == dst_yaau;
                            xaau_ram_load <= y_load && dst == dst_xaau;
                            dau_ram_load  <= y_load && dst == dst_dau;
                            ram_we        <= op == op_y_r;    // Store to RAM
                            rsel          <= rom_dout[8:6];
                            r_field       <= rom_dout[6:4];
                            post_load     <= 1'b1;
                            inc_sel       <= pm_inc;
                            step_sel      <= pm_step;
                            ksel          <= 1'b0;            // Moves step by j only
                            pc_halt       <= 1'b1;
                            double        <= 1'b1;
                        end
                        op_if_con: begin
                            if (!rom_dout[10]) con_check <= 1'b1;
                        end
                        op_do: begin
                            do_data <= rom_dout[instr_w-t_w-1:0];
                            do_load <= 1'b1;
                            if (do_incache) fault <= 1'b1;    // Nested loop
                            if (rom_dout[k_w +: ni_w] == '0) begin   // REDO
                                pc_halt <= 1'b1;
                                double  <= 1'b1;
                            end else begin
                                do_save  <= 1'b1;
                                do_short <= rom_dout[k_w +: ni_w] == ni_t'(1);
                            end
                        end
                        default: fault <= 1'b1;
                    endcase
                end
            end

            // Loop boundary instructions take two slots
            if (do_extend) begin
                pc_halt <= 1'b1;
                double  <= 1'b1;
            end
        end
    end

endmodule
`default_nettype wire

// File: source/irq_gate.sv
`timescale 1ns/10ps
`default_nettype none
/* Interrupt acceptance and acknowledge state */
module irq_gate import dsp_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               ph1,
    input  logic               irq,
    input  logic [instr_w-1:0] rom_dout,
    input  logic               double,
    input  logic               do_busy,
    input  logic               iret_seen,
    output logic               irq_take,
    output logic               iack
);

    opcode_t op;
    logic    blocked;
    logic    clr_arm;   // Clear iack at the next unblocked slot

    assign op = rom_dout[instr_w-1 -: t_w];

    always_comb begin
        blocked = 1'b0;
        for (int i = 0; i < irq_block_n; i++) begin
            if (op == irq_block_ops[i]) blocked = 1'b1;
        end
    end

    // One interrupt at a time, never inside a loop
    assign irq_take = irq && !double && !do_busy && !blocked && !iack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iack    <= 1'b0;
            clr_arm <= 1'b0;
        end else if (ph1) begin
            if (irq_take) begin
                iack    <= 1'b1;
                clr_arm <= 1'b0;
            end else if (!double && !blocked && (clr_arm || iret_seen)) begin
                iack    <= 1'b0;
                clr_arm <= 1'b0;
            end else if (iret_seen) begin
                clr_arm <= 1'b1;
            end
        end
    end

endmodule
`default_nettype wire

// File: sources.f
source/dsp_ctrl_pkg.sv
source/instr_decoder.sv
source/do_loop_ctrl.sv
source/irq_gate.sv
source/dsp_ctrl.sv
verif/dsp_ctrl_tb.sv

// File: verif/dsp_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none
/* Testbench for the DSP controller: directed slots with random ph1 gaps,
   assertions, watchdog and result summary */
module dsp_ctrl_tb import dsp_ctrl_pkg::*; ();

    localparam int total_cycles = 10 + 30 + 16 + 40 + 30 + 70;  // Per test budgets
    localparam logic [15:0] filler = {op_short_imm, 11'h0};      // Harmless slot

    logic clk, rst, ph1, con_result, irq;
    logic [instr_w-1:0] rom_dout;
    logic goto_ja, goto_b, call_ja, pc_halt, con_check;
    logic short_load, long_load, acc_load, ram_load, post_load, ram_we;
    logic xaau_imm_load, xaau_ram_load, xaau_acc_load;
    logic dau_rmux_load, dau_imm_load, dau_ram_load, dau_acc_load;
    logic st_a0, st_a1, st_ah, acc_sel;
    logic [r_w-1:0] rsel, r_field;
    logic [1:0] a_field, y_field, inc_sel;
    logic step_sel, ksel;
    logic [simm_w-1:0] short_imm;
    logic [instr_w-1:0] long_imm;
    logic [i_w-1:0] i_field;
    opcode_t t_field;
    logic irq_start, iack, do_start, do_out, do_short, do_redo, do_save;
    logic [instr_w-t_w-1:0] do_data;
    ni_t do_pc;
    logic fault;
    logic [22:0] strobes;
    integer seed = 32'hef3e;
    integer errors = 0;
    integer test_start_errors, tests_passed = 0, tests_failed = 0;
    integer n_save, n_start, n_out;

    dsp_ctrl dsp_ctrl_inst (.*);

    assign strobes = {goto_ja, goto_b, call_ja, pc_halt, con_check, short_load, long_load,
                      acc_load, ram_load, post_load, ram_we, xaau_imm_load, xaau_ram_load,
                      xaau_acc_load, dau_rmux_load, dau_imm_load, dau_ram_load,
                      dau_acc_load, st_a0, st_a1, st_ah, acc_sel, irq_start};

    always #20 clk = ~clk;

    // A taken branch is followed by an empty slot
    double_slot_clear: assert property (@(posedge clk) disable iff (rst)
        (ph1 && (goto_ja || call_ja) && !dsp_ctrl_inst.do_busy) |=> (strobes == '0))
        else begin
            errors++;
            $display("Fail at %0t: strobes = %0h, expected 0 after a branch", $time, strobes);
        end

    irq_entry: assert property (@(posedge clk) disable iff (rst)
        irq_start |-> (goto_ja && iack && pc_halt))
        else begin
            errors++;
            $display("Fail at %0t: irq_start high without goto_ja, iack and pc_halt", $time);
        end

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // One ph1 slot, sometimes preceded by a frozen cycle
    task automatic run_slot(input logic [15:0] word);
        integer gap;
        gap = (($random(seed) & 3) == 0) ? 1 : 0;
        rom_dout = word;
        repeat (gap) begin
            ph1 = 1'b0;
            @(posedge clk);
            #2;
        end
        ph1 = 1'b1;
        @(posedge clk);
        #2;
        ph1 = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL", name);
        end
        test_start_errors = errors;
    endtask

    function automatic logic [1:0] expected_inc(input logic [1:0] mode);
        case (mode)
            2'd1: return inc_plus1;
            2'd2: return inc_minus1;
            default: return inc_zero;   // *rN and *rN++j
        endcase
    endfunction

    initial begin
        #(total_cycles * 40 * 3 / 2);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        ph1 = 1'b0;
        irq = 1'b0;
        con_result = 1'b0;
        rom_dout = filler;
        test_start_errors = 0;
        repeat (8) begin
            @(posedge clk);
            #2;
            check_val("strobes", strobes, 0);
            check_val("fault/iack/do_start/do_out", {fault, iack, do_start, do_out}, 0);
        end
        rst = 1'b0;
        run_slot(filler);
        check_val("fault/iack/do_start/do_out", {fault, iack, do_start, do_out}, 0);
        finish_test("reset");

        run_slot({op_goto_ja, 11'h123});
        check_val("goto_ja", goto_ja, 1);
        check_val("pc_halt", pc_halt, 1);
        check_val("i_field", i_field, 12'h123);
        check_val("t_field", t_field, op_goto_ja);
        run_slot(filler);
        check_val("strobes", strobes, 0);
        run_slot({op_if_con, 11'h0});
        check_val("con_check", con_check, 1);
        con_result = 1'b0;
        run_slot({op_call_ja, 11'h040});
        check_val("call_ja", call_ja, 0);
        run_slot(filler);
        run_slot({op_if_con, 11'h0});
        run_slot({op_goto_b, 3'b001, 8'h00});   // iret
        check_val("goto_b", goto_b, 1);
        run_slot(filler);
        run_slot(filler);
        finish_test("branches");

        run_slot({op_short_imm[4:1], 3'b101, 9'h1a5});
        check_val("short_load", short_load, 1);
        check_val("r_field", r_field, 3'b001);
        check_val("short_imm", short_imm, 9'h1a5);
        run_slot({op_long_imm, 1'b0, dst_xaau, 7'h25});
        check_val("xaau_imm_load", xaau_imm_load, 1);
        check_val("long_load", long_load, 0);
        check_val("dau_imm_load", dau_imm_load, 0);
        rom_dout = 16'hbeef;
        #1;
        check_val("long_imm", long_imm, 16'hbeef);
        run_slot(16'hbeef);                      // Immediate data slot
        check_val("strobes", strobes, 0);
        finish_test("immediates");

        run_slot({op_y_r, 7'b0, 2'b10, 2'b01});  // *r2++
        check_val("ram_we", ram_we, 1);
        check_val("post_load", post_load, 1);
        check_val("inc_sel", inc_sel, inc_plus1);
        check_val("y_field", y_field, 2'b10);
        run_slot(filler);
        for (int m = 0; m < 4; m++) begin
            run_slot({op_r_y, 1'b0, dst_yaau, 5'b0, 2'(m)});
            check_val("ram_we", ram_we, 0);
            check_val("ram_load", ram_load, 1);
            check_val("inc_sel", inc_sel, expected_inc(2'(m)));
            check_val("step_sel", step_sel, m == 3);
            check_val("ksel", ksel, 0);
            run_slot(filler);
        end
        run_slot({op_r_y, 1'b0, dst_dau, 7'b0});
        check_val("dau_ram_load", dau_ram_load, 1);
        check_val("ram_load", ram_load, 0);
        run_slot(filler);
        run_slot({op_r_a1, 1'b0, dst_xaau, 7'b0});  // R=a1 into an XAAU register
        check_val("xaau_acc_load", xaau_acc_load, 1);
        check_val("acc_sel", acc_sel, 1);
        check_val("rsel", rsel, rsel_dau);
        check_val("a_field[0]", a_field[0], 1);
        run_slot(filler);
        run_slot({op_load_acc_r, 11'h0});
        check_val("dau_rmux_load", dau_rmux_load, 1);
        check_val("st_ah", st_ah, 1);
        run_slot(filler);
        finish_test("ram_moves");

        irq = 1'b1;
        run_slot(filler);
        check_val("irq_start", irq_start, 1);
        check_val("iack", iack, 1);
        irq = 1'b0;
        run_slot(filler);
        run_slot(filler);
        check_val("iack", iack, 1);
        run_slot({op_goto_b, 3'b001, 8'h00});
        check_val("iack", iack, 1);
        run_slot(filler);                        // Branch delay slot
        run_slot(filler);
        check_val("iack", iack, 0);
        irq = 1'b1;
        run_slot({op_if_con, 11'h0});            // Blocking opcode
        check_val("irq_start", irq_start, 0);
        check_val("iack", iack, 0);
        irq = 1'b0;
        run_slot(filler);
        finish_test("interrupts");

        n_save = 0;
        n_start = 0;
        n_out = 0;
        run_slot({op_do, 4'd3, 7'd2});
        check_val("do_data", do_data, {4'd3, 7'd2});
        check_val("do_short", do_short, 0);
        for (int s = 0; s < 24; s++) begin
            n_save += do_save;
            run_slot(filler);
            n_start += do_start;
            n_out += do_out;
        end
        check_val("do_save pulses", n_save, 1);
        check_val("do_start pulses", n_start, 1);
        check_val("do_out pulses", n_out, 1);
        check_val("do_pc", do_pc, 0);
        check_val("do_redo", do_redo, 0);
        check_val("fault", fault, 0);
        run_slot({op_do, 4'd1, 7'd2});           // Single instruction loop
        check_val("do_short", do_short, 1);
        repeat (4) run_slot(filler);
        run_slot({op_do, 4'd3, 7'd3});
        run_slot(filler);
        run_slot({op_goto_ja, 11'h010});         // Branch inside a loop
        check_val("fault", fault, 1);
        finish_test("do_loop");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
`default_nettype wire
